//--- icache_top.f
+incdir+verilog
verilog/icache_fetch_pkg.sv
verilog/icache_fill_pkg.sv
verilog/icache_lookup.sv
verilog/icache_miss_handler.sv
verilog/icache_bypass.sv
verilog/icache_refill.sv
verilog/icache_top.sv
tb/icache_fill_memory.sv
tb/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the instruction cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -Mdir obj_dir -f icache_top.f

status=0
./obj_dir/Vicache_tb > "$log" 2>&1 || status=$?
cat "$log"

if grep -q "Result: FAILED" "$log"; then
  echo "simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Result: PASSED" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

//--- tb/icache_fill_memory.sv
/*
 * Behavioural fill memory for the cache testbench
 * Answers line requests in order after a pseudo-random delay
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_fill_memory import icache_fetch_pkg::*, icache_fill_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_valid_i,
  input  fetch_addr_t req_addr_i,
  output logic        req_ready_o,
  output logic        rsp_valid_o,
  output line_data_t  rsp_data_o,
  output logic        rsp_error_o
);

  fetch_addr_t addr_q [$];
  int          due_q [$];
  int          cycle = 0;
  int          last_due = 0;
  int          due;
  logic [31:0] rng = 32'd3176;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Each word holds the inverted low address half above the low address half
  function automatic line_data_t line_at(input fetch_addr_t base);
    line_data_t  line;
    fetch_addr_t a;
    for (int k = 0; k < `ICACHE_LINE_W / 32; k++) begin
      a = base + fetch_addr_t'(4 * k);
      line[k*32 +: 32] = {~a[15:0], a[15:0]};
    end
    return line;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rsp_error_o = 1'b0;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      addr_q.delete();
      due_q.delete();
      last_due = 0;
    end else begin
      cycle = cycle + 1;
      if (rsp_valid_o) begin
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        rng = xorshift32(rng);
        due = cycle + 3 + int'(rng[1:0]);
        // Responses stay in request order
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        addr_q.push_back(req_addr_i);
        due_q.push_back(due);
      end
    end
    #0.5;
    rng = xorshift32(rng);
    // Ready drops on roughly one cycle in four
    req_ready_o = rst_n_i && (rng[9:8] != 2'b00);
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      rsp_valid_o = 1'b1;
      rsp_data_o  = line_at(addr_q[0]);
      rsp_error_o = addr_q[0][31];
    end else begin
      rsp_valid_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb/icache_golden.txt
// kind port cacheable addr data error fills; kind 0 fetch, 1 fetch paired with the next line
// kind 2 flush with fills only, kind f end; fills are the running total of fill requests
0 0 1 00001004 effb1004 0 01
0 0 1 0000100c eff3100c 0 01
0 1 1 00001008 eff71008 0 01
0 1 0 00002010 dfef2010 0 02
0 1 0 00002014 dfeb2014 0 03
0 0 0 00001000 efff1000 0 04
0 0 1 80000040 ffbf0040 1 05
0 0 1 80000040 ffbf0040 1 06
0 1 0 80000100 feff0100 1 07
0 0 1 00001000 efff1000 0 07
2 0 0 00000000 00000000 0 07
0 0 1 00001000 efff1000 0 08
0 1 1 00001004 effb1004 0 08
1 0 1 00003020 cfdf3020 0 0a
0 1 0 00004030 bfcf4030 0 0a
1 0 0 00005000 afff5000 0 0b
0 1 1 00003028 cfd73028 0 0b
1 0 1 00006004 9ffb6004 0 0d
0 1 1 00007014 8feb7014 0 0d
1 0 0 00008008 7ff78008 0 0f
0 1 0 00009ffc 60039ffc 0 0f
1 0 1 0000100c eff3100c 0 10
0 1 1 00007018 8fe77018 0 10
0 0 1 00006004 9ffb6004 0 11
f 0 0 00000000 00000000 0 00

//--- tb/icache_tb.sv
/*
 * Testbench top for the two-port instruction cache
 * Clock, reset, golden-file driven fetches and flushes, result checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_tb import icache_fetch_pkg::*, icache_fill_pkg::*; ();

  localparam int COLS = 7;
  localparam int GOLDEN_WORDS = 256;
  localparam int WAIT_LIMIT = 300;

  logic clk;
  logic rst_n;

  port_mask_t                         inst_valid, inst_cacheable, inst_ready, inst_error;
  fetch_addr_t [`ICACHE_NR_PORTS-1:0] inst_addr;
  fetch_data_t [`ICACHE_NR_PORTS-1:0] inst_data;
  logic        flush_valid, flush_ready;
  logic        fill_req_valid, fill_req_ready, fill_rsp_valid, fill_rsp_error;
  fetch_addr_t fill_req_addr;
  line_data_t  fill_rsp_data;

  logic [31:0] golden [GOLDEN_WORDS];
  int          fill_count;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (!rst_n) begin
      fill_count <= 0;
    end else if (fill_req_valid && fill_req_ready) begin
      fill_count <= fill_count + 1;
    end
  end

  icache_top icache_top_inst (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .inst_valid_i     ( inst_valid     ),
    .inst_cacheable_i ( inst_cacheable ),
    .inst_addr_i      ( inst_addr      ),
    .inst_ready_o     ( inst_ready     ),
    .inst_data_o      ( inst_data      ),
    .inst_error_o     ( inst_error     ),
    .flush_valid_i    ( flush_valid    ),
    .flush_ready_o    ( flush_ready    ),
    .fill_req_valid_o ( fill_req_valid ),
    .fill_req_addr_o  ( fill_req_addr  ),
    .fill_req_ready_i ( fill_req_ready ),
    .fill_rsp_valid_i ( fill_rsp_valid ),
    .fill_rsp_data_i  ( fill_rsp_data  ),
    .fill_rsp_error_i ( fill_rsp_error )
  );

  icache_fill_memory fill_memory_inst (
    .clk_i       ( clk            ),
    .rst_n_i     ( rst_n          ),
    .req_valid_i ( fill_req_valid ),
    .req_addr_i  ( fill_req_addr  ),
    .req_ready_o ( fill_req_ready ),
    .rsp_valid_o ( fill_rsp_valid ),
    .rsp_data_o  ( fill_rsp_data  ),
    .rsp_error_o ( fill_rsp_error )
  );

  function automatic logic [31:0] field(input int line, input int col);
    return golden[line * COLS + col];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_word(input string name, input fetch_data_t expected,
                            input fetch_data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s data: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_error(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s error: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s fills: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // Inputs change half a nanosecond after the rising edge
  task automatic next_edge();
    @(posedge clk);
    #0.5;
  endtask

  // Starts one or two fetches together and waits for every port to answer
  task automatic run_fetches(input int line, input int lines);
    port_mask_t  pending;
    fetch_data_t exp_data [`ICACHE_NR_PORTS];
    logic        exp_err [`ICACHE_NR_PORTS];
    int          row [`ICACHE_NR_PORTS];
    int          port;
    int          cycles;
    pending = '0;
    cycles = 0;
    next_edge();
    for (int k = 0; k < lines; k++) begin
      port = int'(field(line + k, 1));
      if (port >= `ICACHE_NR_PORTS) abort_run("golden file names a port that does not exist");
      row[port] = line + k;
      exp_data[port] = field(line + k, 4);
      exp_err[port] = field(line + k, 5) != 0;
      inst_cacheable[port] = field(line + k, 2) != 0;
      inst_addr[port] = field(line + k, 3);
      inst_valid[port] = 1'b1;
      pending[port] = 1'b1;
    end
    while (pending != '0) begin
      #1;
      for (int p = 0; p < `ICACHE_NR_PORTS; p++) begin
        if (pending[p] && inst_ready[p]) begin
          check_word($sformatf("txn %0d port %0d", row[p], p), exp_data[p], inst_data[p]);
          check_error($sformatf("txn %0d port %0d", row[p], p), exp_err[p], inst_error[p]);
          pending[p] = 1'b0;
        end
      end
      next_edge();
      inst_valid = inst_valid & pending;
      cycles++;
      if (pending != '0 && cycles > WAIT_LIMIT) begin
        abort_run($sformatf("timeout: fetch at golden line %0d never got inst_ready_o", line));
      end
    end
    for (int k = 0; k < lines; k++) begin
      check_count($sformatf("txn %0d", line + k), int'(field(line + k, 6)), fill_count);
    end
  endtask

  task automatic run_flush(input int line);
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    next_edge();
    flush_valid = 1'b1;
    while (!done) begin
      #1;
      done = flush_ready;
      next_edge();
      if (done) begin
        flush_valid = 1'b0;
      end else begin
        cycles++;
        if (cycles > WAIT_LIMIT) abort_run("timeout: flush was never acknowledged");
      end
    end
    check_count($sformatf("txn %0d flush", line), int'(field(line, 6)), fill_count);
  endtask

  initial begin
    int   line;
    logic finished;
    rst_n = 1'b0;
    inst_valid = '0;
    inst_cacheable = '0;
    inst_addr = '0;
    flush_valid = 1'b0;
    $readmemh("tb/icache_golden.txt", golden);
    repeat (2) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    line = 0;
    finished = 1'b0;
    while (!finished) begin
      if ((line + 1) * COLS > GOLDEN_WORDS || $isunknown(field(line, 0))) begin
        abort_run("golden file is missing, short or has no end line");
      end
      case (int'(field(line, 0)))
        0: begin
          run_fetches(line, 1);
          line += 1;
        end
        1: begin
          run_fetches(line, 2);
          line += 2;
        end
        2: begin
          run_flush(line);
          line += 1;
        end
        15: finished = 1'b1;
        default: abort_run($sformatf("golden line %0d has an unknown kind", line));
      endcase
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/icache_bypass.sv
/*
 * Uncacheable fetch path
 * Per-port state machines, fixed-priority request arbiter,
 * order FIFO and word extraction from the returned line
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_bypass import icache_fetch_pkg::*, icache_fill_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_n_i,

  input  port_mask_t                         in_valid_i,
  input  fetch_addr_t [`ICACHE_NR_PORTS-1:0] in_addr_i,
  output port_mask_t                         in_ready_o,
  output fetch_data_t [`ICACHE_NR_PORTS-1:0] in_data_o,
  output port_mask_t                         in_error_o,

  output logic                               breq_valid_o,
  input  logic                               breq_ready_i,
  output fetch_addr_t                        breq_addr_o,
  input  logic                               brsp_valid_i,
  input  line_data_t                         rsp_line_i,
  input  logic                               rsp_error_i
);

  port_mask_t req_vec, grant, head;
  port_mask_t fifo_q [`ICACHE_BYPASS_FIFO_DEPTH];
  logic [$clog2(`ICACHE_BYPASS_FIFO_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(`ICACHE_BYPASS_FIFO_DEPTH+1)-1:0] count_q;
  logic fifo_full, push, pop;

  // Lowest requesting port wins
  assign grant = req_vec & (~req_vec + 1'b1);
  assign breq_valid_o = |req_vec;

  always_comb begin
    breq_addr_o = '0;
    for (int i = 0; i < `ICACHE_NR_PORTS; i++) begin
      if (grant[i]) begin
        breq_addr_o = line_base(in_addr_i[i]);
      end
    end
  end

  assign fifo_full = (count_q == `ICACHE_BYPASS_FIFO_DEPTH);
  assign push = breq_valid_o && breq_ready_i;
  assign pop  = brsp_valid_i;
  assign head = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + $bits(count_q)'(push) - $bits(count_q)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= grant;
    end
  end

  for (genvar i = 0; i < `ICACHE_NR_PORTS; i++) begin : gen_port
    bypass_state_e state_q;
    fetch_data_t   data_q;
    logic          err_q, rsp_hit;

    // A request is held back while the FIFO has no room for its order entry
    assign req_vec[i] = (state_q == byp_request) && !fifo_full;
    assign rsp_hit = (state_q == byp_wait_rsp) && brsp_valid_i && head[i];
    assign in_ready_o[i] = (state_q == byp_present);
    assign in_data_o[i] = data_q;
    assign in_error_o[i] = err_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        state_q <= byp_idle;
      end else begin
        case (state_q)
          byp_idle: if (in_valid_i[i]) state_q <= byp_request;
          byp_request: if (grant[i] && breq_ready_i) state_q <= byp_wait_rsp;
          byp_wait_rsp: if (rsp_hit) state_q <= byp_present;
          default: state_q <= byp_idle;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (rsp_hit) begin
        data_q <= line_word(rsp_line_i, in_addr_i[i]);
        err_q  <= rsp_error_i;
      end
    end
  end

  // A push never lands on an entry that is still waiting to be read
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      push |-> (wr_ptr_q != rd_ptr_q) || (count_q == '0)
  ) else $error("bypass order FIFO pushed while full");

endmodule

`default_nettype wire

//--- verilog/icache_fetch_pkg.sv
/*
 * Fetch-side types: addresses, instruction words, port masks
 * and the bypass state encoding
 */
`default_nettype none

`include "icache_settings.svh"

package icache_fetch_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;
  typedef logic [`ICACHE_FETCH_DW-1:0] fetch_data_t;

  // One bit per fetch port, one-hot where a single port is meant
  typedef logic [`ICACHE_NR_PORTS-1:0] port_mask_t;

  typedef enum logic [1:0] {
    byp_idle,
    byp_request,
    byp_wait_rsp,
    byp_present
  } bypass_state_e;

endpackage

`default_nettype wire

//--- verilog/icache_fill_pkg.sv
/*
 * Line-side types, refill source and miss handler states
 * Helpers for line alignment and word selection
 */
`default_nettype none

`include "icache_settings.svh"

package icache_fill_pkg;

  typedef logic [`ICACHE_LINE_W-1:0] line_data_t;
  typedef logic [`ICACHE_TAG_W-1:0] line_tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] line_index_t;

  typedef enum logic {src_cache, src_bypass} refill_src_e;

  typedef enum logic [1:0] {
    hdl_idle,
    hdl_refill,
    hdl_write,
    hdl_respond
  } handler_state_e;

  // Address of the first byte of the line holding addr
  function automatic logic [`ICACHE_ADDR_W-1:0] line_base(
      input logic [`ICACHE_ADDR_W-1:0] addr);
    return {addr[`ICACHE_ADDR_W-1:`ICACHE_LINE_ALIGN], {`ICACHE_LINE_ALIGN{1'b0}}};
  endfunction

  // Picks the word that addr points to out of a full line
  function automatic logic [`ICACHE_FETCH_DW-1:0] line_word(
      input line_data_t line, input logic [`ICACHE_ADDR_W-1:0] addr);
    int unsigned sel;
    sel = 32'(addr[`ICACHE_LINE_ALIGN-1:`ICACHE_WORD_ALIGN]);
    return line[sel*`ICACHE_FETCH_DW +: `ICACHE_FETCH_DW];
  endfunction

endpackage

`default_nettype wire

//--- verilog/icache_lookup.sv
/*
 * Round-robin port arbiter, direct-mapped tag/valid/data arrays,
 * registered lookup stage and flush of the valid bits
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_lookup import icache_fetch_pkg::*, icache_fill_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  port_mask_t                          req_valid_i,
  input  fetch_addr_t [`ICACHE_NR_PORTS-1:0]  req_addr_i,
  output port_mask_t                          req_grant_o,

  input  logic                                flush_valid_i,
  output logic                                flush_ready_o,
  input  logic                                handler_busy_i,

  output logic                                look_valid_o,
  input  logic                                look_ready_i,
  output fetch_addr_t                         look_addr_o,
  output port_mask_t                          look_port_o,
  output logic                                look_hit_o,
  output line_data_t                          look_data_o,

  input  logic                                wr_valid_i,
  input  line_index_t                         wr_index_i,
  input  line_tag_t                           wr_tag_i,
  input  line_data_t                          wr_data_i
);

  line_tag_t  tag_q  [`ICACHE_LINE_COUNT];
  line_data_t data_q [`ICACHE_LINE_COUNT];
  logic [`ICACHE_LINE_COUNT-1:0] valid_q;

  logic [`ICACHE_PORT_IDX_W-1:0] last_q, pick;
  logic        pick_found, arb_en;
  fetch_addr_t sel_addr;
  line_index_t sel_index;
  line_tag_t   sel_tag;

  // Lookups wait while a miss is in progress or a flush is pending, so a
  // result never reads a line that is about to change
  assign arb_en = (!look_valid_o || look_ready_i) && !handler_busy_i && !flush_valid_i;
  assign flush_ready_o = flush_valid_i && !handler_busy_i && !look_valid_o;

  // Search starts one past the last granted port
  always_comb begin
    pick = last_q;
    pick_found = 1'b0;
    for (int i = 1; i <= `ICACHE_NR_PORTS; i++) begin
      if (!pick_found && req_valid_i[(last_q + i) % `ICACHE_NR_PORTS]) begin
        pick = `ICACHE_PORT_IDX_W'((last_q + i) % `ICACHE_NR_PORTS);
        pick_found = 1'b1;
      end
    end
  end

  assign req_grant_o = (arb_en && pick_found) ? port_mask_t'(1'b1) << pick : '0;

  assign sel_addr  = req_addr_i[pick];
  assign sel_index = sel_addr[`ICACHE_LINE_ALIGN +: `ICACHE_INDEX_W];
  assign sel_tag   = sel_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      look_valid_o <= 1'b0;
      last_q       <= '0;
      valid_q      <= '0;
    end else begin
      if (|req_grant_o) begin
        look_valid_o <= 1'b1;
        last_q       <= pick;
      end else if (look_ready_i) begin
        look_valid_o <= 1'b0;
      end
      if (flush_ready_o) begin
        valid_q <= '0;
      end else if (wr_valid_i) begin
        valid_q[wr_index_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|req_grant_o) begin
      look_addr_o <= sel_addr;
      look_port_o <= req_grant_o;
      look_hit_o  <= valid_q[sel_index] && (tag_q[sel_index] == sel_tag);
      look_data_o <= data_q[sel_index];
    end
    if (wr_valid_i) begin
      tag_q[wr_index_i]  <= wr_tag_i;
      data_q[wr_index_i] <= wr_data_i;
    end
  end

  // The handler only writes while busy, which holds the flush off
  a_no_write_on_flush : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(wr_valid_i && flush_ready_o)
  ) else $error("array write and flush in the same cycle");

endmodule

`default_nettype wire

//--- verilog/icache_miss_handler.sv
/*
 * Hit/miss decision with a single pending refill
 * Drives the array write and the cached port responses
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_miss_handler import icache_fetch_pkg::*, icache_fill_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        look_valid_i,
  output logic        look_ready_o,
  input  fetch_addr_t look_addr_i,
  input  port_mask_t  look_port_i,
  input  logic        look_hit_i,
  input  line_data_t  look_data_i,
  output logic        handler_busy_o,

  output logic        hreq_valid_o,
  input  logic        hreq_ready_i,
  output fetch_addr_t hreq_addr_o,
  input  logic        hrsp_valid_i,
  input  line_data_t  rsp_line_i,
  input  logic        rsp_error_i,

  output logic        wr_valid_o,
  output line_index_t wr_index_o,
  output line_tag_t   wr_tag_o,
  output line_data_t  wr_data_o,

  output port_mask_t  cache_rsp_valid_o,
  output fetch_data_t cache_rsp_data_o,
  output logic        cache_rsp_error_o
);

  handler_state_e state_q, state_d;
  fetch_addr_t    addr_q;
  port_mask_t     port_q;
  line_data_t     line_q;
  logic           err_q, sent_q, take_miss;

  assign look_ready_o = (state_q == hdl_idle);
  assign take_miss = look_valid_i && look_ready_o && !look_hit_i;
  // Busy already in the cycle a miss is taken, so the lookup stalls at once
  assign handler_busy_o = (state_q != hdl_idle) || take_miss;

  assign hreq_valid_o = (state_q == hdl_refill) && !sent_q;
  assign hreq_addr_o  = line_base(addr_q);

  // Error lines are answered but never become valid in the array
  assign wr_valid_o = (state_q == hdl_write) && !err_q;
  assign wr_index_o = addr_q[`ICACHE_LINE_ALIGN +: `ICACHE_INDEX_W];
  assign wr_tag_o   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign wr_data_o  = line_q;

  always_comb begin
    state_d = state_q;
    cache_rsp_valid_o = '0;
    cache_rsp_data_o = line_word(line_q, addr_q);
    cache_rsp_error_o = err_q;
    case (state_q)
      hdl_idle: begin
        if (look_valid_i && look_hit_i) begin
          cache_rsp_valid_o = look_port_i;
          cache_rsp_data_o = line_word(look_data_i, look_addr_i);
          cache_rsp_error_o = 1'b0;
        end else if (look_valid_i) begin
          state_d = hdl_refill;
        end
      end
      hdl_refill: if (hrsp_valid_i) state_d = hdl_write;
      hdl_write: state_d = hdl_respond;
      hdl_respond: begin
        cache_rsp_valid_o = port_q;
        state_d = hdl_idle;
      end
      default: state_d = hdl_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= hdl_idle;
      sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (hreq_valid_o && hreq_ready_i) begin
        sent_q <= 1'b1;
      end else if (state_d != hdl_refill) begin
        sent_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_miss) begin
      addr_q <= look_addr_i;
      port_q <= look_port_i;
    end
    if (state_q == hdl_refill && hrsp_valid_i) begin
      line_q <= rsp_line_i;
      err_q  <= rsp_error_i;
    end
  end

  // The lookup arbiter must hand over exactly one port per result
  a_port_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) look_valid_i |-> $onehot(look_port_i)
  ) else $error("lookup result without a one-hot port");

endmodule

`default_nettype wire

//--- verilog/icache_refill.sv
/*
 * Shares the fill port between the miss handler and the bypass unit
 * and routes in-order responses back by source
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_refill import icache_fetch_pkg::*, icache_fill_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        hreq_valid_i,
  output logic        hreq_ready_o,
  input  fetch_addr_t hreq_addr_i,
  input  logic        breq_valid_i,
  output logic        breq_ready_o,
  input  fetch_addr_t breq_addr_i,

  output logic        fill_req_valid_o,
  output fetch_addr_t fill_req_addr_o,
  input  logic        fill_req_ready_i,
  input  logic        fill_rsp_valid_i,
  input  line_data_t  fill_rsp_data_i,
  input  logic        fill_rsp_error_i,

  output logic        hrsp_valid_o,
  output logic        brsp_valid_o,
  output line_data_t  rsp_line_o,
  output logic        rsp_error_o
);

  refill_src_e prio_q, sel;
  refill_src_e pend_q [`ICACHE_REFILL_PENDING];
  logic [$clog2(`ICACHE_REFILL_PENDING)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(`ICACHE_REFILL_PENDING+1)-1:0] count_q;
  logic room, push;

  // On contention the source named by prio_q goes first
  always_comb begin
    if (hreq_valid_i && breq_valid_i) sel = prio_q;
    else if (breq_valid_i) sel = src_bypass;
    else sel = src_cache;
  end

  assign room = (count_q < `ICACHE_REFILL_PENDING);
  assign fill_req_valid_o = (hreq_valid_i || breq_valid_i) && room;
  assign fill_req_addr_o = (sel == src_bypass) ? breq_addr_i : hreq_addr_i;
  assign push = fill_req_valid_o && fill_req_ready_i;

  assign hreq_ready_o = room && fill_req_ready_i && (sel == src_cache);
  assign breq_ready_o = room && fill_req_ready_i && (sel == src_bypass);

  assign rsp_line_o   = fill_rsp_data_i;
  assign rsp_error_o  = fill_rsp_error_i;
  assign hrsp_valid_o = fill_rsp_valid_i && (pend_q[rd_ptr_q] == src_cache);
  assign brsp_valid_o = fill_rsp_valid_i && (pend_q[rd_ptr_q] == src_bypass);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q   <= src_cache;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        prio_q   <= refill_src_e'(~sel);
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fill_rsp_valid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + $bits(count_q)'(push) - $bits(count_q)'(fill_rsp_valid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      pend_q[wr_ptr_q] <= sel;
    end
  end

  a_rsp_has_owner : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) fill_rsp_valid_i |-> (count_q != '0)
  ) else $error("fill response with no outstanding request");

endmodule

`default_nettype wire

//--- verilog/icache_settings.svh
/*
 * Instruction cache sizes and depths
 * Alignment widths derived from the line and word sizes
 */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

`define ICACHE_NR_PORTS 2
`define ICACHE_ADDR_W 32
`define ICACHE_FETCH_DW 32
`define ICACHE_LINE_W 128
`define ICACHE_LINE_COUNT 16
`define ICACHE_BYPASS_FIFO_DEPTH 4
`define ICACHE_REFILL_PENDING 2

// Byte offset of a word, byte offset within a line, index and tag widths
`define ICACHE_WORD_ALIGN ($clog2(`ICACHE_FETCH_DW / 8))
`define ICACHE_LINE_ALIGN ($clog2(`ICACHE_LINE_W / 8))
`define ICACHE_INDEX_W ($clog2(`ICACHE_LINE_COUNT))
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_LINE_ALIGN - `ICACHE_INDEX_W)
`define ICACHE_PORT_IDX_W ($clog2(`ICACHE_NR_PORTS))

`endif

//--- verilog/icache_top.sv
/*
 * Two-port instruction cache top level
 * Splits fetches into cached and bypass paths and merges the results
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_top import icache_fetch_pkg::*, icache_fill_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  port_mask_t                           inst_valid_i,
  input  port_mask_t                           inst_cacheable_i,
  input  fetch_addr_t [`ICACHE_NR_PORTS-1:0]   inst_addr_i,
  output port_mask_t                           inst_ready_o,
  output fetch_data_t [`ICACHE_NR_PORTS-1:0]   inst_data_o,
  output port_mask_t                           inst_error_o,

  input  logic                                 flush_valid_i,
  output logic                                 flush_ready_o,

  output logic                                 fill_req_valid_o,
  output fetch_addr_t                          fill_req_addr_o,
  input  logic                                 fill_req_ready_i,
  input  logic                                 fill_rsp_valid_i,
  input  line_data_t                           fill_rsp_data_i,
  input  logic                                 fill_rsp_error_i
);

  port_mask_t  cache_valid, cache_grant, in_flight_q;
  port_mask_t  cache_rsp_valid;
  fetch_data_t cache_rsp_data;
  logic        cache_rsp_error;

  port_mask_t                          byp_valid, byp_ready, byp_error;
  fetch_data_t [`ICACHE_NR_PORTS-1:0]  byp_data;

  logic        look_valid, look_ready, look_hit, handler_busy;
  fetch_addr_t look_addr;
  port_mask_t  look_port;
  line_data_t  look_data;

  logic        wr_valid;
  line_index_t wr_index;
  line_tag_t   wr_tag;
  line_data_t  wr_data;

  logic        hreq_valid, hreq_ready, hrsp_valid;
  logic        breq_valid, breq_ready, brsp_valid;
  fetch_addr_t hreq_addr, breq_addr;
  line_data_t  rsp_line;
  logic        rsp_error;

  // A granted port keeps valid high until its answer, so it is masked meanwhile
  assign cache_valid = inst_valid_i & inst_cacheable_i & ~in_flight_q;
  assign byp_valid   = inst_valid_i & ~inst_cacheable_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= (in_flight_q | cache_grant) & ~cache_rsp_valid;
    end
  end

  for (genvar i = 0; i < `ICACHE_NR_PORTS; i++) begin : gen_merge
    assign inst_ready_o[i] = inst_cacheable_i[i] ? cache_rsp_valid[i] : byp_ready[i];
    assign inst_data_o[i]  = inst_cacheable_i[i] ? cache_rsp_data : byp_data[i];
    assign inst_error_o[i] = inst_cacheable_i[i] ? cache_rsp_error : byp_error[i];
  end

  icache_lookup i_lookup (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .req_valid_i    ( cache_valid   ),
    .req_addr_i     ( inst_addr_i   ),
    .req_grant_o    ( cache_grant   ),
    .flush_valid_i  ( flush_valid_i ),
    .flush_ready_o  ( flush_ready_o ),
    .handler_busy_i ( handler_busy  ),
    .look_valid_o   ( look_valid    ),
    .look_ready_i   ( look_ready    ),
    .look_addr_o    ( look_addr     ),
    .look_port_o    ( look_port     ),
    .look_hit_o     ( look_hit      ),
    .look_data_o    ( look_data     ),
    .wr_valid_i     ( wr_valid      ),
    .wr_index_i     ( wr_index      ),
    .wr_tag_i       ( wr_tag        ),
    .wr_data_i      ( wr_data       )
  );

  icache_miss_handler i_handler (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .look_valid_i      ( look_valid      ),
    .look_ready_o      ( look_ready      ),
    .look_addr_i       ( look_addr       ),
    .look_port_i       ( look_port       ),
    .look_hit_i        ( look_hit        ),
    .look_data_i       ( look_data       ),
    .handler_busy_o    ( handler_busy    ),
    .hreq_valid_o      ( hreq_valid      ),
    .hreq_ready_i      ( hreq_ready      ),
    .hreq_addr_o       ( hreq_addr       ),
    .hrsp_valid_i      ( hrsp_valid      ),
    .rsp_line_i        ( rsp_line        ),
    .rsp_error_i       ( rsp_error       ),
    .wr_valid_o        ( wr_valid        ),
    .wr_index_o        ( wr_index        ),
    .wr_tag_o          ( wr_tag          ),
    .wr_data_o         ( wr_data         ),
    .cache_rsp_valid_o ( cache_rsp_valid ),
    .cache_rsp_data_o  ( cache_rsp_data  ),
    .cache_rsp_error_o ( cache_rsp_error )
  );

  icache_bypass i_bypass (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .in_valid_i   ( byp_valid   ),
    .in_addr_i    ( inst_addr_i ),
    .in_ready_o   ( byp_ready   ),
    .in_data_o    ( byp_data    ),
    .in_error_o   ( byp_error   ),
    .breq_valid_o ( breq_valid  ),
    .breq_ready_i ( breq_ready  ),
    .breq_addr_o  ( breq_addr   ),
    .brsp_valid_i ( brsp_valid  ),
    .rsp_line_i   ( rsp_line    ),
    .rsp_error_i  ( rsp_error   )
  );

  icache_refill i_refill (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .hreq_valid_i     ( hreq_valid       ),
    .hreq_ready_o     ( hreq_ready       ),
    .hreq_addr_i      ( hreq_addr        ),
    .breq_valid_i     ( breq_valid       ),
    .breq_ready_o     ( breq_ready       ),
    .breq_addr_i      ( breq_addr        ),
    .fill_req_valid_o ( fill_req_valid_o ),
    .fill_req_addr_o  ( fill_req_addr_o  ),
    .fill_req_ready_i ( fill_req_ready_i ),
    .fill_rsp_valid_i ( fill_rsp_valid_i ),
    .fill_rsp_data_i  ( fill_rsp_data_i  ),
    .fill_rsp_error_i ( fill_rsp_error_i ),
    .hrsp_valid_o     ( hrsp_valid       ),
    .brsp_valid_o     ( brsp_valid       ),
    .rsp_line_o       ( rsp_line         ),
    .rsp_error_o      ( rsp_error        )
  );

endmodule

`default_nettype wire
